// File: src/pio_pkg.sv
`default_nettype none

package pio_pkg;

  // Host command codes
  typedef enum logic [3:0] {
    ACT_NONE    = 4'd0,
    ACT_INSTR   = 4'd1,
    ACT_PINCTRL = 4'd2,
    ACT_ENABLE  = 4'd3,
    ACT_PUSH    = 4'd4
  } pio_action_e;

  typedef struct packed {
    pio_action_e action;
    logic [4:0]  index;   // Instruction slot
    logic [31:0] din;
  } pio_cmd_t;

  // Values follow the instruction opcode field where one exists
  typedef enum logic [2:0] {
    OP_JMP  = 3'b000,
    OP_NOP  = 3'b010,
    OP_PULL = 3'b100,
    OP_MOV  = 3'b101,
    OP_SET  = 3'b111
  } pio_opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS = 3'b000,
    COND_Y_DEC  = 3'b100,
    COND_X_NE_Y = 3'b101
  } pio_jmp_cond_e;

  typedef enum logic [2:0] {
    DEST_PINS = 3'b000,
    DEST_X    = 3'b001,
    DEST_Y    = 3'b010
  } pio_dest_e;

  typedef struct packed {
    pio_opcode_e   opcode;
    pio_jmp_cond_e cond;
    pio_dest_e     dest;
    logic [4:0]    imm;   // Immediate or jump target
  } pio_op_t;

  typedef struct packed {
    logic valid;
    logic value;
  } pio_pin_cmd_t;

  localparam logic [2:0] pwm_pin_base = 3'd0;

  // Fields are opcode [15:13], delay [12:8], middle [7:5] and imm [4:0]
  localparam logic [0:7][15:0] pwm_program = '{
    16'h8080,  // PULL noblock
    16'hA027,  // MOV X, OSR
    16'hE04F,  // SET Y, 15
    16'h00A5,  // JMP X!=Y, 5
    16'hE001,  // SET PINS, 1
    16'h0083,  // JMP Y--, 3
    16'hE000,  // SET PINS, 0
    16'h0000   // JMP 0
  };

  // Pin base, then enable
  localparam logic [0:1][31:0] pio_config = '{{29'd0, pwm_pin_base}, 32'd1};

endpackage

`default_nettype wire

// File: src/pio_decode.sv
`timescale 1ns/100ps
`default_nettype none

module pio_decode (
  input  wire  [15:0]      instr,
  output pio_pkg::pio_op_t op
);

  pio_pkg::pio_jmp_cond_e mid_cond;
  pio_pkg::pio_dest_e     mid_dest;
  logic                   cond_ok;
  logic                   dest_ok;

  // Middle field read both ways, opcode picks which one counts
  always_comb begin
    cond_ok  = 1'b1;
    mid_cond = pio_pkg::COND_ALWAYS;
    case (instr[7:5])
      3'b000:  mid_cond = pio_pkg::COND_ALWAYS;
      3'b100:  mid_cond = pio_pkg::COND_Y_DEC;
      3'b101:  mid_cond = pio_pkg::COND_X_NE_Y;
      default: cond_ok = 1'b0;
    endcase
  end

  always_comb begin
    dest_ok  = 1'b1;
    mid_dest = pio_pkg::DEST_X;
    case (instr[7:5])
      3'b000:  mid_dest = pio_pkg::DEST_PINS;
      3'b001:  mid_dest = pio_pkg::DEST_X;
      3'b010:  mid_dest = pio_pkg::DEST_Y;
      default: dest_ok = 1'b0;
    endcase
  end

  always_comb begin
    op.opcode = pio_pkg::OP_NOP;
    op.cond   = mid_cond;
    op.dest   = mid_dest;
    op.imm    = instr[4:0];
    case (instr[15:13])
      3'b000: if (cond_ok) op.opcode = pio_pkg::OP_JMP;
      3'b100: if (instr[7]) op.opcode = pio_pkg::OP_PULL;  // PUSH not supported
      // MOV to pins is not supported
      3'b101: if (dest_ok && mid_dest != pio_pkg::DEST_PINS) op.opcode = pio_pkg::OP_MOV;
      3'b111: if (dest_ok) op.opcode = pio_pkg::OP_SET;
      default: op.opcode = pio_pkg::OP_NOP;
    endcase
  end

endmodule

`default_nettype wire

// File: src/pio_execute.sv
`timescale 1ns/100ps
`default_nettype none

module pio_execute (
  input  wire                   clk_25mhz,
  input  wire                   pwr_up_reset_n,
  input  wire                   enable,
  input  pio_pkg::pio_op_t      op,
  input  wire                   fifo_empty,
  input  wire  [31:0]           fifo_data,
  output logic                  fifo_pop,
  output logic [4:0]            pc,
  output pio_pkg::pio_pin_cmd_t pin_cmd
);

  logic [31:0] x;
  logic [31:0] y;
  logic [31:0] osr;
  logic [31:0] mov_src;
  logic [4:0]  pc_next;

  assign pc_next = pc + 5'd1;

  // Noblock pull, nothing happens on an empty FIFO
  assign fifo_pop = enable && (op.opcode == pio_pkg::OP_PULL) && !fifo_empty;

  assign pin_cmd.valid = enable && (op.opcode == pio_pkg::OP_SET) &&
                         (op.dest == pio_pkg::DEST_PINS);
  assign pin_cmd.value = op.imm[0];

  // MOV source select in imm[2:0]
  always_comb begin
    case (op.imm[2:0])
      3'b001:  mov_src = x;
      3'b010:  mov_src = y;
      3'b111:  mov_src = osr;
      default: mov_src = 32'd0;
    endcase
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      pc  <= 5'd0;
      x   <= 32'd0;
      y   <= 32'd0;
      osr <= 32'd0;
    end else if (enable) begin
      pc <= pc_next;
      case (op.opcode)
        pio_pkg::OP_JMP: begin
          case (op.cond)
            pio_pkg::COND_ALWAYS: pc <= op.imm;
            pio_pkg::COND_X_NE_Y: if (x != y) pc <= op.imm;
            pio_pkg::COND_Y_DEC: begin
              if (y != 32'd0)  // Test before decrement
                pc <= op.imm;
              y <= y - 32'd1;
            end
            default: pc <= pc_next;
          endcase
        end
        pio_pkg::OP_PULL: if (!fifo_empty) osr <= fifo_data;
        pio_pkg::OP_MOV: begin
          if (op.dest == pio_pkg::DEST_X)
            x <= mov_src;
          else if (op.dest == pio_pkg::DEST_Y)
            y <= mov_src;
        end
        pio_pkg::OP_SET: begin
          if (op.dest == pio_pkg::DEST_X)
            x <= 32'(op.imm);
          else if (op.dest == pio_pkg::DEST_Y)
            y <= 32'(op.imm);
        end
        default: pc <= pc_next;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/pio_pins.sv
`timescale 1ns/100ps
`default_nettype none

module pio_pins #(
  parameter int NUM_PINS = 8
) (
  input  wire                   clk_25mhz,
  input  wire                   pwr_up_reset_n,
  input  wire  [2:0]            pin_base,
  input  pio_pkg::pio_pin_cmd_t pin_cmd,
  output logic [NUM_PINS-1:0]   gpio_out,
  output logic [NUM_PINS-1:0]   gpio_dir
);

  // Only the pin at the configured base is touched
  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      gpio_out <= '0;
      gpio_dir <= '0;
    end else if (pin_cmd.valid) begin
      gpio_out[pin_base] <= pin_cmd.value;
      gpio_dir[pin_base] <= 1'b1;  // Becomes an output on first write
    end
  end

endmodule

`default_nettype wire

// File: src/pio_core.sv
`timescale 1ns/100ps
`default_nettype none

module pio_core #(
  parameter int NUM_PINS   = 8,
  parameter int FIFO_DEPTH = 4,
  parameter int PROG_LEN   = 8
) (
  input  wire                 clk_25mhz,
  input  wire                 pwr_up_reset_n,
  input  pio_pkg::pio_cmd_t   cmd,
  output logic                fifo_full,
  output logic [NUM_PINS-1:0] gpio_out,
  output logic [NUM_PINS-1:0] gpio_dir
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

  logic [15:0]           instr_mem [32];
  logic [31:0]           fifo_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  fifo_empty;
  logic                  fifo_pop;
  logic                  push_en;
  logic                  enable;
  logic [2:0]            pin_base;
  logic [4:0]            pc;
  pio_pkg::pio_op_t      op;
  pio_pkg::pio_pin_cmd_t pin_cmd;

  assign fifo_full  = (count == CNT_W'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);
  assign push_en    = (cmd.action == pio_pkg::ACT_PUSH) && !fifo_full;

  // Program slots past PROG_LEN are never written
  always_ff @(posedge clk_25mhz) begin
    if (cmd.action == pio_pkg::ACT_INSTR && 32'(cmd.index) < PROG_LEN)
      instr_mem[cmd.index] <= cmd.din[15:0];
    if (push_en)
      fifo_mem[wr_ptr] <= cmd.din;
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      enable   <= 1'b0;
      pin_base <= 3'd0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
    end else begin
      if (cmd.action == pio_pkg::ACT_PINCTRL)
        pin_base <= cmd.din[2:0];
      if (cmd.action == pio_pkg::ACT_ENABLE)
        enable <= cmd.din[0];
      if (push_en)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (fifo_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (push_en && !fifo_pop)
        count <= count + 1'b1;
      else if (fifo_pop && !push_en)
        count <= count - 1'b1;
    end
  end

  pio_decode u_decode (
    .instr (instr_mem[pc]),
    .op    (op)
  );

  pio_execute u_execute (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .enable         (enable),
    .op             (op),
    .fifo_empty     (fifo_empty),
    .fifo_data      (fifo_mem[rd_ptr]),  // FIFO head
    .fifo_pop       (fifo_pop),
    .pc             (pc),
    .pin_cmd        (pin_cmd)
  );

  pio_pins #(
    .NUM_PINS (NUM_PINS)
  ) u_pins (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .pin_base       (pin_base),
    .pin_cmd        (pin_cmd),
    .gpio_out       (gpio_out),
    .gpio_dir       (gpio_dir)
  );

endmodule

`default_nettype wire

// File: src/pio_loader.sv
`timescale 1ns/100ps
`default_nettype none

module pio_loader #(
  parameter int PROG_LEN = 8
) (
  input  wire                    clk_25mhz,
  input  wire                    pwr_up_reset_n,
  input  wire  [3:0]             level,
  input  wire                    fifo_full,
  output pio_pkg::pio_cmd_t      cmd,
  output logic                   ready
);

  localparam int IDX_W = $clog2(PROG_LEN);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PROG_LEN - 1);

  typedef enum logic [1:0] {
    LOAD_PROG,
    LOAD_CONF,
    RUN
  } load_state_e;

  load_state_e      state;
  logic [IDX_W-1:0] prog_idx;
  logic             conf_idx;
  logic [3:0]       level_q;
  logic             primed;      // First duty value sent
  logic             pend_valid;
  logic [31:0]      pend_data;
  logic [31:0]      duty;
  logic             push_ok;

  // Level 0 gives a count that Y never matches, so the pin stays low
  assign duty = (level == 4'd0) ? 32'h0000_FFFF : 32'(level) - 32'd1;

  // FIFO full flag lags a push by one cycle
  assign push_ok = !fifo_full && (cmd.action != pio_pkg::ACT_PUSH);

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      state      <= LOAD_PROG;
      prog_idx   <= '0;
      conf_idx   <= 1'b0;
      level_q    <= 4'd0;
      primed     <= 1'b0;
      pend_valid <= 1'b0;
      ready      <= 1'b0;
      cmd.action <= pio_pkg::ACT_NONE;
    end else begin
      cmd.action <= pio_pkg::ACT_NONE;
      case (state)
        LOAD_PROG: begin
          cmd.action <= pio_pkg::ACT_INSTR;
          cmd.index  <= 5'(prog_idx);
          cmd.din    <= 32'(pio_pkg::pwm_program[prog_idx]);
          prog_idx   <= prog_idx + 1'b1;
          if (prog_idx == LAST_IDX)
            state <= LOAD_CONF;
        end
        LOAD_CONF: begin
          cmd.din  <= pio_pkg::pio_config[conf_idx];
          conf_idx <= 1'b1;
          if (!conf_idx) begin
            cmd.action <= pio_pkg::ACT_PINCTRL;
          end else begin
            cmd.action <= pio_pkg::ACT_ENABLE;
            state      <= RUN;
          end
        end
        RUN: begin
          ready   <= 1'b1;
          level_q <= level;
          if (pend_valid && push_ok) begin
            cmd.action <= pio_pkg::ACT_PUSH;
            cmd.din    <= pend_data;
            pend_valid <= 1'b0;
          end
          // A newer level replaces one still waiting for space
          if (level != level_q || !primed) begin
            pend_data  <= duty;
            pend_valid <= 1'b1;
            primed     <= 1'b1;
          end
        end
        default: state <= LOAD_PROG;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/pio_top.sv
`timescale 1ns/100ps
`default_nettype none

module pio_top #(
  parameter int NUM_PINS   = 8,
  parameter int FIFO_DEPTH = 4,
  parameter int PROG_LEN   = 8
) (
  input  wire                 clk_25mhz,
  input  wire                 pwr_up_reset_n,
  input  wire  [3:0]          level,
  output logic [NUM_PINS-1:0] gpio_out,
  output logic [NUM_PINS-1:0] gpio_dir,
  output logic                ready
);

  pio_pkg::pio_cmd_t cmd;        // One-cycle command strobe
  logic              fifo_full;

  pio_loader #(
    .PROG_LEN (PROG_LEN)
  ) u_loader (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .level          (level),
    .fifo_full      (fifo_full),
    .cmd            (cmd),
    .ready          (ready)
  );

  pio_core #(
    .NUM_PINS   (NUM_PINS),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_LEN   (PROG_LEN)
  ) u_core (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cmd            (cmd),
    .fifo_full      (fifo_full),
    .gpio_out       (gpio_out),
    .gpio_dir       (gpio_dir)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_25mhz,
  output logic pwr_up_reset_n
);

  initial begin
    clk_25mhz = 1'b0;
    forever #(PERIOD_NS / 2) clk_25mhz = ~clk_25mhz;
  end

  // Released on a falling edge, like every other input
  initial begin
    pwr_up_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    pwr_up_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/pio_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module pio_assertions #(
  parameter int NUM_PINS = 8,
  parameter int PROG_LEN = 8
) (
  input  wire                 clk_25mhz,
  input  wire                 pwr_up_reset_n,
  input  pio_pkg::pio_cmd_t   cmd,
  input  wire                 fifo_full,
  input  wire  [4:0]          pc,
  input  wire                 enable,
  input  wire  [NUM_PINS-1:0] gpio_dir
);

  // Loader has to honor back-pressure
  push_not_full: assert property (
    @(posedge clk_25mhz) disable iff (!pwr_up_reset_n)
    (cmd.action == pio_pkg::ACT_PUSH) |-> !fifo_full
  ) else $error("push issued while the TX FIFO is full");

  pc_in_program: assert property (
    @(posedge clk_25mhz) disable iff (!pwr_up_reset_n)
    32'(pc) < PROG_LEN
  ) else $error("program counter left the loaded program");

  // No pin may turn into an output before the block runs
  dir_idle_until_enable: assert property (
    @(posedge clk_25mhz) disable iff (!pwr_up_reset_n)
    !enable |-> (gpio_dir == '0)
  ) else $error("gpio_dir changed before enable");

endmodule

`default_nettype wire

// File: dv/tb_pio.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pio;

  localparam int NUM_PINS    = 8;
  localparam int FIFO_DEPTH  = 4;
  localparam int PROG_LEN    = 8;
  localparam int CLK_NS      = 40;
  localparam int PERIOD      = 38;   // Loop length for X <= 15
  localparam int SEED        = 41;
  localparam int NUM_ENTRIES = 18;
  localparam int LOW_HOLD    = 84;   // Level 0 watch window
  localparam int BURST_TRIES = FIFO_DEPTH + 4;  // FIFO drain, pending word, settling
  localparam logic [NUM_PINS-1:0] PIN0       = NUM_PINS'(1);
  localparam logic [NUM_PINS-1:0] UPPER_MASK = ~PIN0;
  // Per entry at most 3 periods of settling plus two measured pulses
  localparam int WATCHDOG_NS =
    (NUM_ENTRIES * 8 * PERIOD + BURST_TRIES * 3 * PERIOD + 64) * CLK_NS;

  typedef struct packed {
    logic [3:0] level;
    int         exp_high;
    int         exp_period;  // 0 when the pin must stay low
  } entry_t;

  // High time is 2L cycles of every loop, level 0 never drives high
  entry_t stim [NUM_ENTRIES] = '{
    '{4'd5, 10, PERIOD}, '{4'd1, 2, PERIOD}, '{4'd15, 30, PERIOD},
    '{4'd0, 0, 0}, '{4'd8, 16, PERIOD}, '{4'd3, 6, PERIOD},
    '{4'd12, 24, PERIOD}, '{4'd2, 4, PERIOD}, '{4'd0, 0, 0},
    '{4'd14, 28, PERIOD}, '{4'd7, 14, PERIOD}, '{4'd10, 20, PERIOD},
    '{4'd4, 8, PERIOD}, '{4'd13, 26, PERIOD}, '{4'd6, 12, PERIOD},
    '{4'd11, 22, PERIOD}, '{4'd9, 18, PERIOD}, '{4'd0, 0, 0}
  };
  logic [3:0] burst_levels [6] = '{4'd3, 4'd11, 4'd6, 4'd14, 4'd1, 4'd9};

  logic                clk_25mhz;
  logic                pwr_up_reset_n;
  logic [3:0]          level;
  logic [NUM_PINS-1:0] gpio_out;
  logic [NUM_PINS-1:0] gpio_dir;
  logic                ready;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_NS),
    .RESET_CYCLES (5)
  ) u_clk_gen (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n)
  );

  pio_top #(
    .NUM_PINS   (NUM_PINS),
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_LEN   (PROG_LEN)
  ) u_dut (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .level          (level),
    .gpio_out       (gpio_out),
    .gpio_dir       (gpio_dir),
    .ready          (ready)
  );

  bind pio_core pio_assertions #(
    .NUM_PINS (NUM_PINS),
    .PROG_LEN (PROG_LEN)
  ) u_assertions (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cmd            (cmd),
    .fifo_full      (fifo_full),
    .pc             (pc),
    .enable         (enable),
    .gpio_dir       (gpio_dir)
  );

  task automatic end_in_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pins(input logic [NUM_PINS-1:0] got, input logic [NUM_PINS-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[ERROR] t=%0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  // Rise to rise on pin 0, sampled on falling edges
  task automatic measure_pulse(input int lvl, output int high, output int period);
    int waited;
    waited = 0;
    high   = 0;
    @(negedge clk_25mhz);
    while (gpio_out[0] !== 1'b0 && waited < 3 * PERIOD) begin
      @(negedge clk_25mhz);
      waited++;
    end
    while (gpio_out[0] !== 1'b1 && waited < 3 * PERIOD) begin
      @(negedge clk_25mhz);
      waited++;
    end
    if (gpio_out[0] !== 1'b1) begin
      $display("Pin 0 never went high while level was %0d", lvl);
      end_in_failure();
    end
    while (gpio_out[0] === 1'b1 && high < 2 * PERIOD) begin
      high++;
      @(negedge clk_25mhz);
    end
    period = high;
    while (gpio_out[0] === 1'b0 && period < 2 * PERIOD) begin
      period++;
      @(negedge clk_25mhz);
    end
  endtask

  // Upper pins are never addressed by the program
  always @(negedge clk_25mhz) begin
    if (pwr_up_reset_n === 1'b1) begin
      check_pins(gpio_out & UPPER_MASK, '0, "gpio_out pins 7:1");
      check_pins(gpio_dir & UPPER_MASK, '0, "gpio_dir pins 7:1");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the test ran far longer than its table allows and was stopped");
    end_in_failure();
  end

  initial begin
    int high;
    int period;
    int waited;
    int found;
    level = 4'd0;
    void'($urandom(SEED));
    @(posedge pwr_up_reset_n);
    @(negedge clk_25mhz);
    check_pins(gpio_out, '0, "gpio_out after reset");
    check_pins(gpio_dir, '0, "gpio_dir after reset");
    check_ready(ready, 1'b0, "ready after reset");
    waited = 0;
    while (ready !== 1'b1 && waited < 16) begin
      @(negedge clk_25mhz);
      waited++;
    end
    check_ready(ready, 1'b1, "ready 16 cycles after reset");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(negedge clk_25mhz);
      level = stim[i].level;
      repeat (2 * PERIOD + int'($urandom_range(PERIOD - 1, 0))) @(negedge clk_25mhz);
      if (stim[i].exp_period == 0) begin
        repeat (LOW_HOLD) begin
          @(negedge clk_25mhz);
          check_pins(gpio_out, '0, "gpio_out at level 0");
        end
        check_pins(gpio_dir, PIN0, "gpio_dir at level 0");
      end else begin
        repeat (2) begin
          measure_pulse(stim[i].level, high, period);
          check_count(high, stim[i].exp_high, $sformatf("high time at level %0d", stim[i].level));
          check_count(period, stim[i].exp_period, $sformatf("period at level %0d", stim[i].level));
        end
      end
    end

    // Six changes in 18 cycles overrun the 4-deep FIFO
    foreach (burst_levels[j]) begin
      @(negedge clk_25mhz);
      level = burst_levels[j];
      repeat (2) @(negedge clk_25mhz);
    end
    found = 0;
    for (int k = 0; k < BURST_TRIES && found == 0; k++) begin
      measure_pulse(9, high, period);
      if (high == 18 && period == PERIOD)
        found = 1;
    end
    check_count(high, 18, "high time after burst ending at level 9");
    check_count(period, PERIOD, "period after burst ending at level 9");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/pio_pkg.sv
src/pio_decode.sv
src/pio_execute.sv
src/pio_pins.sv
src/pio_core.sv
src/pio_loader.sv
src/pio_top.sv
dv/tb_clk_gen.sv
dv/pio_assertions.sv
dv/tb_pio.sv

// File: Makefile
TOP    = tb_pio
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(OBJDIR) -o V$(TOP) -f sources.f

run: build
	./$(OBJDIR)/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf $(OBJDIR) sim.log
